//--- source/mipsPkg.sv
package mipsPkg;

	////////////////////////////////////////////////////////////////////////////
	// field widths
	////////////////////////////////////////////////////////////////////////////

	localparam int regAddrW = 5;
	localparam int dataW    = 32;

	////////////////////////////////////////////////////////////////////////////
	// instruction encodings
	////////////////////////////////////////////////////////////////////////////

	// primary opcode, bits 31:26
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJ       = 6'h02,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddiu   = 6'h09,
		opOri     = 6'h0d,
		opLui     = 6'h0f,
		opLw      = 6'h23,
		opSw      = 6'h2b
	} opcodeE;

	// function field of special, bits 5:0
	typedef enum logic [5:0] {
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnXor  = 6'h26,
		fnSlt  = 6'h2a
	} functE;

	// internal control encodings
	typedef enum logic [3:0] {aluAdd, aluSub, aluAnd, aluOr, aluXor, aluSlt, aluLui} aluOpE;
	typedef enum logic {fromAlu, fromMem} resultSelE;
	typedef enum logic [1:0] {fwdReg, fwdWb, fwdMem} fwdSelE;

endpackage

//--- source/instrDecoder.sv
`timescale 1ns/1ps

module instrDecoder (
	input  logic [mipsPkg::dataW-1:0] instr,
	output logic                      regWrite,
	output logic                      memWrite,
	output logic                      memRead,
	output logic                      aluSrcImm,
	output logic                      zeroExtend,
	output logic                      regDstRd,
	output logic                      branch,
	output logic                      branchNe,
	output logic                      jump,
	output mipsPkg::aluOpE            aluOp,
	output mipsPkg::resultSelE        resultSel
);

	mipsPkg::opcodeE opcode;
	mipsPkg::functE  funct;

	assign opcode = mipsPkg::opcodeE'(instr[31:26]);
	assign funct  = mipsPkg::functE'(instr[5:0]);

	always_comb begin
		// anything not listed falls through as a nop
		regWrite   = 1'b0;
		memWrite   = 1'b0;
		memRead    = 1'b0;
		aluSrcImm  = 1'b0;
		zeroExtend = 1'b0;
		regDstRd   = 1'b0;
		branch     = 1'b0;
		branchNe   = 1'b0;
		jump       = 1'b0;
		aluOp      = mipsPkg::aluAdd;
		resultSel  = mipsPkg::fromAlu;
		case (opcode)
			mipsPkg::opSpecial: begin
				regDstRd = 1'b1;
				regWrite = 1'b1;
				case (funct)
					mipsPkg::fnAddu: aluOp = mipsPkg::aluAdd;
					mipsPkg::fnSubu: aluOp = mipsPkg::aluSub;
					mipsPkg::fnAnd:  aluOp = mipsPkg::aluAnd;
					mipsPkg::fnOr:   aluOp = mipsPkg::aluOr;
					mipsPkg::fnXor:  aluOp = mipsPkg::aluXor;
					mipsPkg::fnSlt:  aluOp = mipsPkg::aluSlt;
					// shifts, hi/lo, jr etc. are not supported
					default:         regWrite = 1'b0;
				endcase
			end
			mipsPkg::opAddiu: begin
				regWrite  = 1'b1;
				aluSrcImm = 1'b1;
			end
			mipsPkg::opOri: begin
				regWrite   = 1'b1;
				aluSrcImm  = 1'b1;
				zeroExtend = 1'b1;
				aluOp      = mipsPkg::aluOr;
			end
			mipsPkg::opLui: begin
				regWrite  = 1'b1;
				aluSrcImm = 1'b1;
				aluOp     = mipsPkg::aluLui;
			end
			mipsPkg::opLw: begin
				regWrite  = 1'b1;
				memRead   = 1'b1;
				aluSrcImm = 1'b1;
				resultSel = mipsPkg::fromMem;
			end
			mipsPkg::opSw: begin
				memWrite  = 1'b1;
				aluSrcImm = 1'b1;
			end
			mipsPkg::opBeq: branch = 1'b1;
			mipsPkg::opBne: begin
				branch   = 1'b1;
				branchNe = 1'b1;
			end
			mipsPkg::opJ: jump = 1'b1;
			default: ;
		endcase
	end

endmodule

//--- source/regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic                         clk,
	input  logic                         rstN,
	input  logic [mipsPkg::regAddrW-1:0] readAddrA,
	input  logic [mipsPkg::regAddrW-1:0] readAddrB,
	output logic [mipsPkg::dataW-1:0]    readDataA,
	output logic [mipsPkg::dataW-1:0]    readDataB,
	input  logic                         writeEn,
	input  logic [mipsPkg::regAddrW-1:0] writeAddr,
	input  logic [mipsPkg::dataW-1:0]    writeData
);

	// $0 has no storage
	logic [mipsPkg::dataW-1:0] regs [1:31];

	always_ff @(posedge clk) begin
		if (!rstN) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// same-cycle write shows up on the read side
	assign readDataA = (readAddrA == '0) ? '0 :
		(writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 :
		(writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

//--- source/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
	input  logic [mipsPkg::regAddrW-1:0] rsD,
	input  logic [mipsPkg::regAddrW-1:0] rtD,
	input  logic [mipsPkg::regAddrW-1:0] rsE,
	input  logic [mipsPkg::regAddrW-1:0] rtE,
	input  logic                         branchD,
	input  logic [mipsPkg::regAddrW-1:0] writeRegE,
	input  logic [mipsPkg::regAddrW-1:0] writeRegM,
	input  logic [mipsPkg::regAddrW-1:0] writeRegW,
	input  logic                         regWriteE,
	input  logic                         regWriteM,
	input  logic                         regWriteW,
	input  logic                         memReadE,
	input  logic                         memReadM,
	input  logic                         memBusy,
	output mipsPkg::fwdSelE              fwdAE,
	output mipsPkg::fwdSelE              fwdBE,
	output logic                         fwdAD,
	output logic                         fwdBD,
	output logic                         stallF,
	output logic                         stallD,
	output logic                         stallE,
	output logic                         stallM,
	output logic                         stallW,
	output logic                         flushE
);

	logic hitMA, hitMB, hitWA, hitWB;
	logic loadUse, branchWait, hold;

	// execute operands, memory stage wins over writeback
	assign hitMA = regWriteM && writeRegM != '0 && writeRegM == rsE;
	assign hitMB = regWriteM && writeRegM != '0 && writeRegM == rtE;
	assign hitWA = regWriteW && writeRegW != '0 && writeRegW == rsE;
	assign hitWB = regWriteW && writeRegW != '0 && writeRegW == rtE;

	assign fwdAE = hitMA ? mipsPkg::fwdMem : hitWA ? mipsPkg::fwdWb : mipsPkg::fwdReg;
	assign fwdBE = hitMB ? mipsPkg::fwdMem : hitWB ? mipsPkg::fwdWb : mipsPkg::fwdReg;

	// branch compare in decode, writeback is covered by the regfile bypass
	assign fwdAD = regWriteM && writeRegM != '0 && writeRegM == rsD;
	assign fwdBD = regWriteM && writeRegM != '0 && writeRegM == rtD;

	// load result not ready until writeback
	assign loadUse = memReadE && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD);

	// branch source still in execute, or a load sitting in memory
	assign branchWait = branchD && (
		(regWriteE && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD)) ||
		(memReadM && writeRegM != '0 && (writeRegM == rsD || writeRegM == rtD)));

	assign hold = loadUse | branchWait;

	// bus wait freezes everything, bubble only when execute may move
	assign stallF = memBusy | hold;
	assign stallD = memBusy | hold;
	assign stallE = memBusy;
	assign stallM = memBusy;
	assign stallW = memBusy;
	assign flushE = hold & ~memBusy;

endmodule

//--- source/aluUnit.sv
`timescale 1ns/1ps

module aluUnit (
	input  logic [mipsPkg::dataW-1:0] opA,
	input  logic [mipsPkg::dataW-1:0] opB,
	input  mipsPkg::aluOpE            aluOp,
	output logic [mipsPkg::dataW-1:0] result
);

	logic lessThan;

	// signed compare for slt
	assign lessThan = $signed(opA) < $signed(opB);

	always_comb begin
		case (aluOp)
			// wraps, no overflow trap
			mipsPkg::aluAdd: result = opA + opB;
			mipsPkg::aluSub: result = opA - opB;
			mipsPkg::aluAnd: result = opA & opB;
			mipsPkg::aluOr:  result = opA | opB;
			mipsPkg::aluXor: result = opA ^ opB;
			mipsPkg::aluSlt: result = {{(mipsPkg::dataW-1){1'b0}}, lessThan};
			// immediate into the upper half
			mipsPkg::aluLui: result = {opB[15:0], 16'h0000};
			default:         result = '0;
		endcase
	end

endmodule

//--- source/wbDataPort.sv
`timescale 1ns/1ps

module wbDataPort (
	input  logic                      clk,
	input  logic                      rstN,
	input  logic                      memRead,
	input  logic                      memWrite,
	input  logic [mipsPkg::dataW-1:0] addr,
	input  logic [mipsPkg::dataW-1:0] writeData,
	output logic [mipsPkg::dataW-1:0] readData,
	output logic                      busy,
	output logic                      wbCyc,
	output logic                      wbStb,
	output logic                      wbWe,
	output logic [mipsPkg::dataW-1:0] wbAdr,
	output logic [mipsPkg::dataW-1:0] wbWriteData,
	input  logic                      wbAck,
	input  logic [mipsPkg::dataW-1:0] wbReadData
);

	typedef enum logic {idle, waitAck} stateE;

	stateE state;
	logic  done;
	logic  req;
	logic  start;

	assign req   = memRead | memWrite;
	// done blocks a reissue while the finished access is still in memory stage
	assign start = (state == idle) && req && !done;
	assign busy  = start || (state == waitAck);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= idle;
			done  <= 1'b0;
			wbCyc <= 1'b0;
			wbStb <= 1'b0;
			wbWe  <= 1'b0;
		end else begin
			case (state)
				idle: begin
					// pipeline moves on in this cycle
					if (done) begin
						done <= 1'b0;
					end else if (req) begin
						state <= waitAck;
						wbCyc <= 1'b1;
						wbStb <= 1'b1;
						wbWe  <= memWrite;
					end
				end
				waitAck: begin
					if (wbAck) begin
						state <= idle;
						done  <= 1'b1;
						wbCyc <= 1'b0;
						wbStb <= 1'b0;
						wbWe  <= 1'b0;
					end
				end
				default: state <= idle;
			endcase
		end
	end

	// address and data stay put for the whole cycle
	always_ff @(posedge clk) begin
		if (start) begin
			wbAdr       <= addr;
			wbWriteData <= writeData;
		end
		if (state == waitAck && wbAck) begin
			readData <= wbReadData;
		end
	end

endmodule

//--- source/mipsCore.sv
`timescale 1ns/1ps

module mipsCore #(
	parameter logic [mipsPkg::dataW-1:0] resetPc = '0
) (
	input  logic                         clk,
	input  logic                         rstN,
	output logic [mipsPkg::dataW-1:0]    pcF,
	input  logic [mipsPkg::dataW-1:0]    instrF,
	output logic                         wbCyc,
	output logic                         wbStb,
	output logic                         wbWe,
	output logic [mipsPkg::dataW-1:0]    wbAdr,
	output logic [mipsPkg::dataW-1:0]    wbWriteData,
	input  logic                         wbAck,
	input  logic [mipsPkg::dataW-1:0]    wbReadData,
	output logic [mipsPkg::dataW-1:0]    debugPc,
	output logic                         debugRfWen,
	output logic [mipsPkg::regAddrW-1:0] debugRfNum,
	output logic [mipsPkg::dataW-1:0]    debugRfData
);

	// fetch / decode
	logic [mipsPkg::dataW-1:0] pcNext, pcPlus4F, instrD, pcD, pcPlus4D;
	logic [mipsPkg::dataW-1:0] immD, branchTargetD, jumpTargetD;
	logic [mipsPkg::dataW-1:0] rdAD, rdBD, cmpAD, cmpBD;
	logic [mipsPkg::regAddrW-1:0] rsD, rtD, rdD;
	logic regWriteD, memWriteD, memReadD, aluSrcImmD, zeroExtendD, regDstRdD;
	logic branchD, branchNeD, jumpD, takenD;
	mipsPkg::aluOpE     aluOpD;
	mipsPkg::resultSelE resultSelD;
	// execute
	logic [mipsPkg::dataW-1:0] srcAE, srcBE, immE, pcE, fwdValAE, fwdValBE, aluBE, aluOutE;
	logic [mipsPkg::regAddrW-1:0] rsE, rtE, rdE, writeRegE;
	logic regWriteE, memWriteE, memReadE, aluSrcImmE, regDstRdE;
	mipsPkg::aluOpE     aluOpE;
	mipsPkg::resultSelE resultSelE;
	// memory / writeback
	logic [mipsPkg::dataW-1:0] aluOutM, writeDataM, pcM, readDataM;
	logic [mipsPkg::dataW-1:0] aluOutW, readDataW, pcW, resultW;
	logic [mipsPkg::regAddrW-1:0] writeRegM, writeRegW;
	logic regWriteM, memWriteM, memReadM, regWriteW, rfWenW, memBusy;
	mipsPkg::resultSelE resultSelM, resultSelW;
	// hazard controls
	mipsPkg::fwdSelE fwdAE, fwdBE;
	logic fwdAD, fwdBD, stallF, stallD, stallE, stallM, stallW, flushE;

	////////////////////////////////////////////////////////////////////////////
	// fetch
	////////////////////////////////////////////////////////////////////////////

	assign pcPlus4F = pcF + 32'd4;
	// branch or jump in decode steers the slot after the delay slot
	assign pcNext = jumpD ? jumpTargetD : takenD ? branchTargetD : pcPlus4F;

	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcF <= resetPc;
		end else if (!stallF) begin
			pcF <= pcNext;
		end
	end

	// F/D, cleared word decodes as nop
	always_ff @(posedge clk) begin
		if (!rstN) begin
			instrD <= '0;
		end else if (!stallD) begin
			instrD <= instrF;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD) begin
			pcD <= pcF;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// decode
	////////////////////////////////////////////////////////////////////////////

	assign rsD = instrD[25:21];
	assign rtD = instrD[20:16];
	assign rdD = instrD[15:11];
	assign immD = zeroExtendD ? {16'h0000, instrD[15:0]} : {{16{instrD[15]}}, instrD[15:0]};
	assign pcPlus4D = pcD + 32'd4;
	assign branchTargetD = pcPlus4D + {immD[29:0], 2'b00};
	assign jumpTargetD = {pcPlus4D[31:28], instrD[25:0], 2'b00};

	instrDecoder instrDecoder_inst (
		.instr(instrD), .regWrite(regWriteD), .memWrite(memWriteD), .memRead(memReadD),
		.aluSrcImm(aluSrcImmD), .zeroExtend(zeroExtendD), .regDstRd(regDstRdD),
		.branch(branchD), .branchNe(branchNeD), .jump(jumpD),
		.aluOp(aluOpD), .resultSel(resultSelD)
	);

	regFile regFile_inst (
		.clk(clk), .rstN(rstN), .readAddrA(rsD), .readAddrB(rtD),
		.readDataA(rdAD), .readDataB(rdBD),
		.writeEn(rfWenW), .writeAddr(writeRegW), .writeData(resultW)
	);

	// equality compare on forwarded operands
	assign cmpAD  = fwdAD ? aluOutM : rdAD;
	assign cmpBD  = fwdBD ? aluOutM : rdBD;
	assign takenD = branchD & ((cmpAD == cmpBD) ^ branchNeD);

	hazardUnit hazardUnit_inst (
		.rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE), .branchD(branchD),
		.writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
		.regWriteE(regWriteE), .regWriteM(regWriteM), .regWriteW(regWriteW),
		.memReadE(memReadE), .memReadM(memReadM), .memBusy(memBusy),
		.fwdAE(fwdAE), .fwdBE(fwdBE), .fwdAD(fwdAD), .fwdBD(fwdBD),
		.stallF(stallF), .stallD(stallD), .stallE(stallE), .stallM(stallM),
		.stallW(stallW), .flushE(flushE)
	);

	// D/E, bubble clears only the side-effect bits
	always_ff @(posedge clk) begin
		if (!rstN || (flushE && !stallE)) begin
			regWriteE <= 1'b0;
			memWriteE <= 1'b0;
			memReadE  <= 1'b0;
		end else if (!stallE) begin
			regWriteE <= regWriteD;
			memWriteE <= memWriteD;
			memReadE  <= memReadD;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallE) begin
			srcAE      <= rdAD;
			srcBE      <= rdBD;
			immE       <= immD;
			rsE        <= rsD;
			rtE        <= rtD;
			rdE        <= rdD;
			pcE        <= pcD;
			aluSrcImmE <= aluSrcImmD;
			regDstRdE  <= regDstRdD;
			aluOpE     <= aluOpD;
			resultSelE <= resultSelD;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// execute
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (fwdAE)
			mipsPkg::fwdMem: fwdValAE = aluOutM;
			mipsPkg::fwdWb:  fwdValAE = resultW;
			default:         fwdValAE = srcAE;
		endcase
		case (fwdBE)
			mipsPkg::fwdMem: fwdValBE = aluOutM;
			mipsPkg::fwdWb:  fwdValBE = resultW;
			default:         fwdValBE = srcBE;
		endcase
	end

	assign aluBE     = aluSrcImmE ? immE : fwdValBE;
	assign writeRegE = regDstRdE ? rdE : rtE;

	aluUnit aluUnit_inst (.opA(fwdValAE), .opB(aluBE), .aluOp(aluOpE), .result(aluOutE));

	// E/M
	always_ff @(posedge clk) begin
		if (!rstN) begin
			regWriteM <= 1'b0;
			memWriteM <= 1'b0;
			memReadM  <= 1'b0;
		end else if (!stallM) begin
			regWriteM <= regWriteE;
			memWriteM <= memWriteE;
			memReadM  <= memReadE;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallM) begin
			aluOutM    <= aluOutE;
			writeDataM <= fwdValBE;
			writeRegM  <= writeRegE;
			resultSelM <= resultSelE;
			pcM        <= pcE;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// memory and writeback
	////////////////////////////////////////////////////////////////////////////

	wbDataPort wbDataPort_inst (
		.clk(clk), .rstN(rstN), .memRead(memReadM), .memWrite(memWriteM),
		.addr(aluOutM), .writeData(writeDataM), .readData(readDataM), .busy(memBusy),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbWriteData(wbWriteData), .wbAck(wbAck), .wbReadData(wbReadData)
	);

	// M/W
	always_ff @(posedge clk) begin
		if (!rstN) begin
			regWriteW <= 1'b0;
		end else if (!stallW) begin
			regWriteW <= regWriteM;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallW) begin
			aluOutW    <= aluOutM;
			readDataW  <= readDataM;
			writeRegW  <= writeRegM;
			resultSelW <= resultSelM;
			pcW        <= pcM;
		end
	end

	assign resultW = (resultSelW == mipsPkg::fromMem) ? readDataW : aluOutW;
	// retire once, in the last cycle of a bus hold
	assign rfWenW = regWriteW & ~stallW;

	assign debugPc     = pcW;
	assign debugRfWen  = rfWenW;
	assign debugRfNum  = writeRegW;
	assign debugRfData = resultW;

endmodule

//--- verification/wbMemModel.sv
`timescale 1ns/1ps

module wbMemModel (
	input  logic        clk,
	input  logic        rstN,
	input  logic [31:0] pcF,
	output logic [31:0] instrF,
	input  logic        wbCyc,
	input  logic        wbStb,
	input  logic        wbWe,
	input  logic [31:0] wbAdr,
	input  logic [31:0] wbWriteData,
	output logic        wbAck,
	output logic [31:0] wbReadData
);

	// program words filled by the testbench
	logic [31:0] instrMem [0:1023];
	// word addressed data words
	logic [31:0] dataMem [0:255];
	integer seed;
	int waitLeft;

	initial begin
		seed = 32'h8da28393;
		wbAck <= 1'b0;
		wbReadData <= '0;
		for (int i = 0; i < 256; i++) begin
			dataMem[i] <= '0;
		end
		// wait states before the first acknowledge
		waitLeft <= $random(seed) & 3;
	end

	// fetch answers in the same cycle
	assign instrF = instrMem[pcF[11:2]];

	// slave side moves on the falling edge
	always @(negedge clk) begin
		if (!rstN) begin
			wbAck <= 1'b0;
		end else begin
			wbAck <= 1'b0;
			if (wbCyc && wbStb && !wbAck) begin
				if (waitLeft == 0) begin
					wbAck <= 1'b1;
					if (wbWe) begin
						dataMem[wbAdr[9:2]] <= wbWriteData;
					end else begin
						wbReadData <= dataMem[wbAdr[9:2]];
					end
					// 0 to 3 wait states for the next access
					waitLeft <= $random(seed) & 3;
				end else begin
					waitLeft <= waitLeft - 1;
				end
			end
		end
	end

endmodule

//--- verification/mipsCoreTb.sv
`timescale 1ns/1ps

module mipsCoreTb;

	localparam logic [31:0] resetPc = 32'h0000_0000;

	logic        clk;
	logic        rstN;
	logic [31:0] pcF;
	logic [31:0] instrF;
	logic        wbCyc;
	logic        wbStb;
	logic        wbWe;
	logic [31:0] wbAdr;
	logic [31:0] wbWriteData;
	logic        wbAck;
	logic [31:0] wbReadData;
	logic [31:0] debugPc;
	logic        debugRfWen;
	logic [4:0]  debugRfNum;
	logic [31:0] debugRfData;

	// expected data from the pattern file
	logic [31:0] progWords [$];
	logic [31:0] expPc [$];
	logic [4:0]  expNum [$];
	logic [31:0] expData [$];
	logic [31:0] memAddr [$];
	logic [31:0] memData [$];

	int errors;
	int checks;
	int retired;
	int testErrors;
	bit retireOn;
	bit loaded;

	////////////////////////////////////////////////////////////////////////////
	// clock, DUT and memory
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	mipsCore #(.resetPc(resetPc)) mipsCore_inst (
		.clk(clk), .rstN(rstN), .pcF(pcF), .instrF(instrF),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbWriteData(wbWriteData), .wbAck(wbAck), .wbReadData(wbReadData),
		.debugPc(debugPc), .debugRfWen(debugRfWen), .debugRfNum(debugRfNum),
		.debugRfData(debugRfData)
	);

	wbMemModel memModel_inst (
		.clk(clk), .rstN(rstN), .pcF(pcF), .instrF(instrF),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbWriteData(wbWriteData), .wbAck(wbAck), .wbReadData(wbReadData)
	);

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	// I is a program word, R a retirement, M a final memory word
	task automatic readPatterns();
		int fd;
		int code;
		logic [63:0] tag;
		logic [1023:0] line;
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0] n;
		fd = $fopen("verification/corePatterns.txt", "r");
		if (fd == 0) begin
			$display("cannot open the pattern file");
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, "%s", tag);
			if (code != 1) begin
				break;
			end
			if (tag == "#") begin
				code = $fgets(line, fd);
			end else if (tag == "I") begin
				code = $fscanf(fd, "%h", a);
				progWords.push_back(a);
			end else if (tag == "R") begin
				code = $fscanf(fd, "%h %h %h", a, n, b);
				expPc.push_back(a);
				expNum.push_back(n);
				expData.push_back(b);
			end else if (tag == "M") begin
				code = $fscanf(fd, "%h %h", a, b);
				memAddr.push_back(a);
				memData.push_back(b);
			end else begin
				$display("unknown record in the pattern file");
				errors++;
			end
		end
		$fclose(fd);
	endtask

	// unused words decode as nop
	task automatic loadProgram();
		for (int i = 0; i < 1024; i++) begin
			memModel_inst.instrMem[i] = '0;
		end
		foreach (progWords[i]) begin
			memModel_inst.instrMem[i] = progWords[i];
		end
	endtask

	task automatic compareWord(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			$display("ERR %0t %s got %h expected %h", $time, name, got, exp);
			errors++;
		end
	endtask

	// one record per register write in program order
	task automatic checkRetire();
		if (retired >= expPc.size()) begin
			$display("unexpected extra retirement at %0t, pc %h", $time, debugPc);
			errors++;
		end else begin
			compareWord("debugPc", debugPc, expPc[retired]);
			compareWord("debugRfNum", {27'd0, debugRfNum}, {27'd0, expNum[retired]});
			compareWord("debugRfData", debugRfData, expData[retired]);
		end
		retired++;
	endtask

	always @(negedge clk) begin
		if (retireOn && debugRfWen) begin
			checkRetire();
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// watchdog
	////////////////////////////////////////////////////////////////////////////

	initial begin
		int limit;
		wait (loaded);
		limit = 40 * expPc.size() + 200;
		repeat (limit) @(posedge clk);
		$display("timeout after %0d cycles, %0d of %0d retirements seen",
			limit, retired, expPc.size());
		$display("Finished with errors");
		$finish;
	end

	////////////////////////////////////////////////////////////////////////////
	// main sequence
	////////////////////////////////////////////////////////////////////////////

	initial begin
		errors = 0;
		checks = 0;
		retired = 0;
		retireOn = 1'b0;
		rstN = 1'b0;
		readPatterns();
		loadProgram();
		loaded = 1'b1;

		// bus stays idle and nothing retires during reset
		testErrors = errors;
		repeat (10) begin
			@(negedge clk);
			compareWord("wbCyc", {31'd0, wbCyc}, 32'd0);
			compareWord("wbStb", {31'd0, wbStb}, 32'd0);
			compareWord("wbWe", {31'd0, wbWe}, 32'd0);
			compareWord("debugRfWen", {31'd0, debugRfWen}, 32'd0);
		end
		rstN = 1'b1;
		compareWord("pcF", pcF, resetPc);
		// only nops in flight in the first cycle out of reset
		@(negedge clk);
		compareWord("wbCyc", {31'd0, wbCyc}, 32'd0);
		compareWord("debugRfWen", {31'd0, debugRfWen}, 32'd0);
		$display("test reset finished, %0d errors", errors - testErrors);

		// program run checks retirement order and values
		testErrors = errors;
		retireOn = 1'b1;
		while (retired < expPc.size()) begin
			@(negedge clk);
		end
		// drain while the program spins in its self loop
		repeat (20) @(negedge clk);
		$display("test retirement finished, %0d of %0d seen, %0d errors",
			retired, expPc.size(), errors - testErrors);

		// stored words in the data array
		testErrors = errors;
		foreach (memAddr[i]) begin
			compareWord($sformatf("dataMem[%h]", memAddr[i]),
				memModel_inst.dataMem[memAddr[i][9:2]], memData[i]);
		end
		$display("test memory finished, %0d errors", errors - testErrors);

		$display("checks %0d, retirements %0d, errors %0d", checks, retired, errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

//--- verification/corePatterns.txt
# all fields hex: I word | R pc reg data | M byteaddr data
# program from pc 0, retirements in program order
I 3C011234
I 34215678
I 2402FFFF
I 00221821
I 00612023
I 00622824
I 00813025
I 00A13826
I 0047402A
I 00E2482A
I 240A0100
I AD410000
I AD470004
I 8D4B0000
I 01676021
I 8D4D0004
I 11A70002
I 240E0001
I 240F0BAD
I 15C00002
I 24100002
I 240F0BAD
I 11D00002
I 24110003
I 16100005
I 24120004
I 0800001D
I 24130005
I 240F0BAD
I AD4C0008
I 8D540008
I 0800001F
I 00000000
R 00000000 01 12340000
R 00000004 01 12345678
R 00000008 02 FFFFFFFF
R 0000000C 03 12345677
R 00000010 04 FFFFFFFF
R 00000014 05 12345677
R 00000018 06 FFFFFFFF
R 0000001C 07 0000000F
R 00000020 08 00000001
R 00000024 09 00000000
R 00000028 0A 00000100
R 00000034 0B 12345678
R 00000038 0C 12345687
R 0000003C 0D 0000000F
R 00000044 0E 00000001
R 00000050 10 00000002
R 0000005C 11 00000003
R 00000064 12 00000004
R 0000006C 13 00000005
R 00000078 14 12345687
M 00000100 12345678
M 00000104 0000000F
M 00000108 12345687

//--- all.f
source/mipsPkg.sv
source/instrDecoder.sv
source/regFile.sv
source/hazardUnit.sv
source/aluUnit.sv
source/wbDataPort.sv
source/mipsCore.sv
verification/wbMemModel.sv
verification/mipsCoreTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
rm -f build.log sim.log

verilator --binary --timing --top-module mipsCoreTb -f all.f -o simv > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
if [ $? -ne 0 ]; then
	echo "simulation exited with an error, see sim.log"
	exit 1
fi

if grep -q "Finished with errors" sim.log; then
	echo "FAIL"
	exit 1
fi

echo "PASS"
exit 0
